/* Bender.yml */
package:
  name: fdc_wd1793

sources:
  - files:
      - source/fdc_pkg.sv
      - source/fdc_ctrl_if.sv
      - source/fdc_geom_if.sv
      - source/fdc_host_regs.sv
      - source/fdc_geometry.sv
      - source/fdc_cmd_seq.sv
      - source/fdc_top.sv
  - target: simulation
    files:
      - sim/fdc_asserts.sv
      - sim/fdc_tb.sv

/* sim/fdc_asserts.sv */
// ====================
// Protocol assertions for the command sequencer, bound into
// fdc_cmd_seq. Covers drq, the image port strobes and force interrupt.
// ====================

`timescale 1ns/1ps
`default_nettype none

module fdc_asserts (
	input logic           clk_sys,
	input logic           rst_n,
	input logic           busy,
	input logic           drq,
	input logic           img_rd,
	input logic           img_wr,
	input logic           cmd_we,
	input fdc_pkg::byte_t cmd
);

	int unsigned fails = 0;

	// data requests only inside a command
	drq_needs_busy: assert property (@(posedge clk_sys) disable iff (!rst_n) drq |-> busy)
		else begin
			$error("drq raised while the sequencer is not busy");
			fails++;
		end

	img_port_excl: assert property (@(posedge clk_sys) disable iff (!rst_n) !(img_rd && img_wr))
		else begin
			$error("image read and write strobes high together");
			fails++;
		end

	// force interrupt drops busy quickly
	force_int_idle: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(cmd_we && cmd[7:4] == 4'hd) |-> ##[1:2] !busy)
		else begin
			$error("busy still high two cycles after force interrupt");
			fails++;
		end

endmodule

bind fdc_cmd_seq fdc_asserts u_asserts (
	.clk_sys (clk_sys),
	.rst_n   (rst_n),
	.busy    (ctrl.busy),
	.drq     (ctrl.drq),
	.img_rd  (img_rd),
	.img_wr  (img_wr),
	.cmd_we  (ctrl.cmd_we),
	.cmd     (ctrl.cmd)
);

`default_nettype wire

/* sim/fdc_tb.sv */
// ====================
// Testbench for the floppy controller top level. A table of type I and
// type II commands runs against a 1 MB image memory model. Each entry
// checks the registers, the status byte, the bytes moved and the image.
// ====================

`timescale 1ns/1ps
`default_nettype none

module fdc_tb;

	typedef enum {act_step, act_read, act_write, act_hold, act_abort} act_e;

	typedef struct {
		string      name;
		logic [7:0] cmd;
		logic [7:0] track;       // seek target, or expected track register for type I
		logic [7:0] sector;
		logic       side;
		logic       layout;
		logic [2:0] size_code;
		logic       wp;
		logic       ready;
		act_e       act;
		logic [7:0] exp_status;
	} entry_t;

	// about 1400 sector bytes at ~25 cycles each, plus command overhead
	localparam int timeout_cycles = 50000;

	logic                clk_sys;
	logic                rst_n;
	logic                rd, wr, wp, ready, side, layout;
	logic                drq, intrq, busy, img_rd, img_wr;
	fdc_pkg::reg_addr_e  addr;
	fdc_pkg::byte_t      din, dout, img_wdata;
	fdc_pkg::byte_t      img_rdata = '0;
	fdc_pkg::geom_code_t size_code;
	fdc_pkg::img_addr_t  disk_size, img_addr;

	fdc_pkg::byte_t mem [0:(1 << 20) - 1];   // image model
	int             img_writes = 0;
	int             cycles = 0;
	int             errors = 0;
	int             passed = 0;
	int             failed = 0;
	logic           test_bad;
	entry_t         tests[$];

	fdc_top #(.lost_timeout(256)) dut (
		.clk_sys (clk_sys), .rst_n (rst_n),
		.rd (rd), .wr (wr), .addr (addr), .din (din), .dout (dout),
		.drq (drq), .intrq (intrq), .busy (busy),
		.wp (wp), .ready (ready), .side (side), .layout (layout),
		.size_code (size_code), .disk_size (disk_size),
		.img_addr (img_addr), .img_rd (img_rd), .img_wr (img_wr),
		.img_wdata (img_wdata), .img_rdata (img_rdata)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// image memory, one cycle read latency
	always @(posedge clk_sys) begin
		if (img_rd)
			img_rdata <= mem[img_addr[19:0]];
		if (img_wr) begin
			mem[img_addr[19:0]] <= img_wdata;
			img_writes <= img_writes + 1;
		end
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("timeout: the run did not finish within %0d cycles", timeout_cycles);
			$display("** FAIL **");
			$finish;
		end
	end

	// ====================
	// geometry reference
	// ====================
	function automatic int spt_of(input logic [2:0] code);
		case (code)
			3'd1:    return 16;
			3'd2:    return 9;
			3'd3:    return 5;
			3'd4:    return 10;
			default: return 26;
		endcase
	endfunction

	function automatic int len_of(input logic [2:0] code);
		case (code)
			3'd1:       return 256;
			3'd2, 3'd4: return 512;
			3'd3:       return 1024;
			default:    return 128;
		endcase
	endfunction

	function automatic int sector_base(input entry_t e, input int sec);
		int idx;
		int base;
		idx  = e.layout ? e.track : e.track * 2 + e.side;
		base = (idx * spt_of(e.size_code) + sec - 1) * len_of(e.size_code);
		if (e.layout && e.side)
			base = base + disk_size / 2;   // side 1 in the upper half
		return base;
	endfunction

	function automatic int bytes_expected(input entry_t e);
		int spt;
		spt = spt_of(e.size_code);
		if (e.act != act_read && e.act != act_write)
			return 0;
		if ((e.act == act_write && e.wp) || !e.ready || e.sector == 0 || e.sector > spt)
			return 0;
		if (e.cmd[4])
			return (spt - e.sector + 1) * len_of(e.size_code);   // up to the last sector
		return len_of(e.size_code);
	endfunction

	// ====================
	// bus and check tasks
	// ====================
	task automatic bus_write(input fdc_pkg::reg_addr_e a, input fdc_pkg::byte_t v);
		@(negedge clk_sys);
		addr = a;
		din  = v;
		wr   = 1'b1;
		@(negedge clk_sys);
		wr = 1'b0;
	endtask

	task automatic bus_read(input fdc_pkg::reg_addr_e a, output fdc_pkg::byte_t v);
		@(negedge clk_sys);
		addr = a;
		rd   = 1'b1;
		@(negedge clk_sys);
		v  = dout;
		rd = 1'b0;
	endtask

	task automatic issue_cmd(input fdc_pkg::byte_t c);
		bus_write(fdc_pkg::cmd_status, c);
	endtask

	task automatic wait_intrq();
		while (!intrq)
			@(negedge clk_sys);
	endtask

	task automatic check_val(input string name, input string what,
	                         input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("ERR %s %s: expected %0h, actual %0h", name, what, exp, act);
			errors++;
			test_bad = 1'b1;
		end
	endtask

	task automatic add_test(input string name, input int c, input int trk, input int sec,
	                        input int sd, input int lay, input int code, input int prot,
	                        input int rdy, input act_e act, input int exp);
		entry_t e;
		e.name       = name;
		e.cmd        = 8'(c);
		e.track      = 8'(trk);
		e.sector     = 8'(sec);
		e.side       = sd[0];
		e.layout     = lay[0];
		e.size_code  = 3'(code);
		e.wp         = prot[0];
		e.ready      = rdy[0];
		e.act        = act;
		e.exp_status = 8'(exp);
		tests.push_back(e);
	endtask

	task automatic run_entry(input entry_t e);
		fdc_pkg::byte_t v;
		fdc_pkg::byte_t wbytes[$];
		int count;
		int wr_start;
		int len;
		len   = len_of(e.size_code);
		count = 0;
		@(negedge clk_sys);
		side      = e.side;
		layout    = e.layout;
		size_code = e.size_code;
		wp        = e.wp;
		ready     = e.ready;
		bus_write(fdc_pkg::data, e.track);
		if (e.act != act_step) begin
			issue_cmd(8'h10);              // seek to the target track
			wait_intrq();
			bus_read(fdc_pkg::cmd_status, v);
			bus_write(fdc_pkg::sector, e.sector);
		end
		wr_start = img_writes;
		issue_cmd(e.cmd);
		case (e.act)
			act_read, act_write: begin
				while (!intrq) begin
					if (drq) begin
						if (e.act == act_read) begin
							bus_read(fdc_pkg::data, v);
							check_val(e.name, "read byte",
							          mem[sector_base(e, e.sector + count / len) + count % len], v);
						end else begin
							v = 8'($urandom);
							wbytes.push_back(v);
							bus_write(fdc_pkg::data, v);
						end
						count++;
						while (drq)
							@(negedge clk_sys);
					end else begin
						@(negedge clk_sys);
					end
				end
				foreach (wbytes[i])
					check_val(e.name, "image byte", wbytes[i],
					          mem[sector_base(e, e.sector + i / len) + i % len]);
			end
			act_abort: begin
				while (!drq && !intrq)
					@(negedge clk_sys);
				issue_cmd(8'hd0);
				wait_intrq();
			end
			default: wait_intrq();         // type I, or drq left waiting
		endcase
		check_val(e.name, "byte count", bytes_expected(e), count);
		check_val(e.name, "image writes", e.act == act_write ? bytes_expected(e) : 0,
		          img_writes - wr_start);
		check_val(e.name, "busy", 0, busy);
		check_val(e.name, "drq", 0, drq);
		if (e.act == act_step) begin
			bus_read(fdc_pkg::track, v);
			check_val(e.name, "track", e.track, v);
		end
		bus_read(fdc_pkg::cmd_status, v);
		check_val(e.name, "status", e.exp_status, v);
		@(negedge clk_sys);
		check_val(e.name, "intrq after status read", 0, intrq);
	endtask

	initial begin
		fdc_pkg::byte_t v;
		rst_n     = 1'b0;
		rd        = 1'b0;
		wr        = 1'b0;
		addr      = fdc_pkg::cmd_status;
		din       = '0;
		wp        = 1'b0;
		ready     = 1'b1;
		side      = 1'b0;
		layout    = 1'b0;
		size_code = '0;
		disk_size = 21'h100000;           // 1 MB image
		void'($urandom(32'h5ec0));
		for (int i = 0; i < (1 << 20); i++)
			mem[i] = 8'($urandom);
		repeat (16) @(negedge clk_sys);
		rst_n = 1'b1;

		test_bad = 1'b0;
		bus_read(fdc_pkg::cmd_status, v);
		check_val("reset_state", "status", 8'h04, v);
		check_val("reset_state", "intrq", 0, intrq);
		check_val("reset_state", "busy", 0, busy);
		check_val("reset_state", "drq", 0, drq);
		$display("reset_state: %s", test_bad ? "failed" : "ok");
		if (test_bad)
			failed++;
		else
			passed++;

		//       name             cmd  trk sec sd ly sz wp rdy action     status
		add_test("restore_hl",    'h08, 0,  0, 0, 0, 0, 0, 1, act_step,  'h24);
		add_test("seek_5",        'h10, 5,  0, 0, 0, 0, 0, 1, act_step,  'h00);
		add_test("step_in_upd",   'h50, 6,  0, 0, 0, 0, 0, 1, act_step,  'h00);
		add_test("step_in",       'h40, 6,  0, 0, 0, 0, 0, 1, act_step,  'h00);
		add_test("step_out_upd",  'h70, 6,  0, 0, 0, 0, 0, 1, act_step,  'h00);
		add_test("step_upd",      'h30, 5,  0, 0, 0, 0, 0, 1, act_step,  'h00);
		add_test("step_out",      'h60, 5,  0, 0, 0, 0, 0, 1, act_step,  'h00);
		add_test("restore",       'h00, 0,  0, 0, 0, 0, 0, 1, act_step,  'h04);
		add_test("rd_sc0_l0_s1",  'h80, 2,  3, 1, 0, 0, 0, 1, act_read,  'h00);
		add_test("rd_sc1_l1_s1",  'h80, 1, 16, 1, 1, 1, 0, 1, act_read,  'h00);
		add_test("rd_sc2_l0_s0",  'h80, 4,  9, 0, 0, 2, 0, 1, act_read,  'h00);
		add_test("wr_sc0_l1_s0",  'ha0, 3,  7, 0, 1, 0, 0, 1, act_write, 'h00);
		add_test("wr_protected",  'ha0, 3,  7, 0, 1, 0, 1, 1, act_write, 'h60);
		add_test("rd_multi",      'h90, 1, 25, 0, 0, 0, 0, 1, act_read,  'h10);
		add_test("rnf_sector_0",  'h80, 0,  0, 0, 0, 3, 0, 1, act_read,  'h10);
		add_test("rnf_above_spt", 'h80, 2, 11, 1, 0, 4, 0, 1, act_read,  'h10);
		add_test("not_ready",     'h80, 1,  1, 0, 0, 0, 0, 0, act_read,  'h90);
		add_test("lost_data",     'h80, 2,  1, 0, 0, 0, 0, 1, act_hold,  'h04);
		add_test("force_int",     'h80, 2,  2, 0, 0, 0, 0, 1, act_abort, 'h00);

		foreach (tests[i]) begin
			test_bad = 1'b0;
			run_entry(tests[i]);
			$display("%s: %s", tests[i].name, test_bad ? "failed" : "ok");
			if (test_bad)
				failed++;
			else
				passed++;
		end

		errors = errors + dut.u_seq.u_asserts.fails;
		$display("tests %0d, passed %0d, failed %0d, errors %0d",
		         passed + failed, passed, failed, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

/* source/fdc_cmd_seq.sv */
// ====================
// Command sequencer. Decodes type I, type II and force interrupt,
// tracks the head, moves sector bytes between the image memory and
// the data register one at a time, and builds the status byte.
// ====================

`timescale 1ns/1ps
`default_nettype none

module fdc_cmd_seq #(
	parameter int settle_cycles = 64,
	parameter int search_cycles = 32,
	parameter int drq_delay     = 16,
	parameter int lost_timeout  = 4096
) (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  logic                wp,
	input  logic                ready,
	output fdc_pkg::img_addr_t  img_addr,
	output logic                img_rd,
	output logic                img_wr,
	output fdc_pkg::byte_t      img_wdata,
	input  fdc_pkg::byte_t      img_rdata,
	fdc_ctrl_if.seq             ctrl,
	fdc_geom_if.seq             geom
);

	localparam int cw = $clog2(settle_cycles + search_cycles + drq_delay + lost_timeout);

	fdc_pkg::seq_state_e state;
	logic [cw-1:0]       wait_cnt;
	logic [cw-1:0]       wd_cnt;      // lost data watchdog
	fdc_pkg::track_t     head_pos;    // physical head position
	logic                step_out;    // last step direction, 1 = outward
	logic                head_loaded;
	logic                seek_err;    // seek error / record not found
	logic                wr_fault;
	logic                lost_data;
	logic                type2;       // status byte form
	logic                multi;
	logic                is_write;
	fdc_pkg::sec_len_t   byte_cnt;

	wire             dir_out   = ctrl.cmd[6] ? ctrl.cmd[5] : step_out;
	wire             last_byte = byte_cnt == fdc_pkg::sec_len_t'(geom.sec_len - 1'b1);
	wire             xfer_done = is_write ? ctrl.data_wr_done : ctrl.data_rd_done;
	fdc_pkg::track_t next_track;

	always_comb begin
		if (!dir_out)
			next_track = head_pos + 1'b1;
		else if (head_pos == '0)
			next_track = '0;    // stop at track 0
		else
			next_track = head_pos - 1'b1;
	end

	assign geom.head   = head_pos;
	assign geom.sector = ctrl.sector_reg;

	// image port, one byte in flight
	assign img_addr  = geom.base + fdc_pkg::img_addr_t'(byte_cnt);
	assign img_rd    = (state == fdc_pkg::fetch);
	assign img_wr    = (state == fdc_pkg::store) && is_write;
	assign img_wdata = ctrl.data_reg;

	always_comb begin
		if (type2)
			ctrl.status = {~ready, wp & is_write, wr_fault, seek_err | ~ready,
			               1'b0, lost_data, ctrl.drq, ctrl.busy};
		else
			ctrl.status = {~ready, wp, head_loaded, seek_err | ~ready,
			               1'b0, head_pos == '0, 1'b0, ctrl.busy};  // no index pulse
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state            <= fdc_pkg::idle;
			wait_cnt         <= '0;
			wd_cnt           <= '0;
			head_pos         <= '0;
			step_out         <= 1'b0;
			head_loaded      <= 1'b0;
			{seek_err, wr_fault, lost_data} <= '0;
			type2            <= 1'b0;
			multi            <= 1'b0;
			is_write         <= 1'b0;
			byte_cnt         <= '0;
			ctrl.busy        <= 1'b0;
			ctrl.drq         <= 1'b0;
			ctrl.cmd_done    <= 1'b0;
			ctrl.track_ld    <= 1'b0;
			ctrl.sector_ld   <= 1'b0;
			ctrl.fetched_vld <= 1'b0;
		end else begin
			ctrl.cmd_done  <= 1'b0;
			ctrl.track_ld  <= 1'b0;
			ctrl.sector_ld <= 1'b0;
			if (wd_cnt != '0)
				wd_cnt <= wd_cnt - 1'b1;

			case (state)
				fdc_pkg::settle: begin
					if (wait_cnt != '0)
						wait_cnt <= wait_cnt - 1'b1;
					else
						state <= fdc_pkg::end_cmd;
				end
				fdc_pkg::search: begin
					if (!ready) begin
						seek_err <= 1'b1;
						state    <= fdc_pkg::end_cmd;
					end else if (wait_cnt != '0) begin
						wait_cnt <= wait_cnt - 1'b1;
					end else if (!geom.in_range) begin
						seek_err <= 1'b1;      // record not found
						state    <= fdc_pkg::end_cmd;
					end else begin
						wait_cnt <= cw'(drq_delay - 1);
						state    <= is_write ? fdc_pkg::drq_delay : fdc_pkg::fetch;
					end
				end
				fdc_pkg::fetch:
					state <= fdc_pkg::fetch_wait;
				fdc_pkg::fetch_wait: begin
					ctrl.fetched     <= img_rdata;
					ctrl.fetched_vld <= 1'b1;
					wait_cnt         <= cw'(drq_delay - 1);
					state            <= fdc_pkg::drq_delay;
				end
				fdc_pkg::drq_delay: begin
					if (wait_cnt != '0) begin
						wait_cnt <= wait_cnt - 1'b1;
					end else begin
						ctrl.drq <= 1'b1;
						wd_cnt   <= cw'(lost_timeout - 1);
						state    <= fdc_pkg::drq_wait;
					end
				end
				fdc_pkg::drq_wait: begin
					if (xfer_done || wd_cnt == '0) begin
						ctrl.drq <= 1'b0;
						if (!xfer_done)
							lost_data <= 1'b1;
						state <= fdc_pkg::store;
					end
				end
				fdc_pkg::store: begin
					// lost data ends the transfer after this byte
					if (lost_data) begin
						state <= fdc_pkg::end_cmd;
					end else if (!last_byte) begin
						byte_cnt <= byte_cnt + 1'b1;
						wait_cnt <= cw'(drq_delay - 1);
						state    <= is_write ? fdc_pkg::drq_delay : fdc_pkg::fetch;
					end else if (multi) begin
						ctrl.sector_ld  <= 1'b1;
						ctrl.sector_val <= ctrl.sector_reg + 1'b1;
						byte_cnt        <= '0;
						wait_cnt        <= cw'(search_cycles - 1);
						state           <= fdc_pkg::search;
					end else begin
						state <= fdc_pkg::end_cmd;
					end
				end
				fdc_pkg::abort: begin
					{seek_err, wr_fault, lost_data} <= '0;
					ctrl.fetched_vld <= 1'b0;
					ctrl.cmd_done    <= 1'b1;
					state            <= fdc_pkg::idle;
				end
				fdc_pkg::end_cmd: begin
					ctrl.busy        <= 1'b0;
					ctrl.drq         <= 1'b0;
					ctrl.fetched_vld <= 1'b0;
					ctrl.cmd_done    <= 1'b1;
					state            <= fdc_pkg::idle;
				end
				default: ;
			endcase

			// ==================
			// command decode
			// ==================
			if (ctrl.cmd_we && (state == fdc_pkg::idle || ctrl.cmd[7:4] == 4'hd)) begin
				type2 <= ctrl.cmd[7];
				case (ctrl.cmd[7:4])
					4'h0: begin              // restore
						head_pos        <= '0;
						ctrl.track_ld   <= 1'b1;
						ctrl.track_val  <= '0;
					end
					4'h1: begin              // seek to data register
						head_pos        <= ctrl.data_reg;
						ctrl.track_ld   <= 1'b1;
						ctrl.track_val  <= ctrl.data_reg;
					end
					4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7: begin
						if (ctrl.cmd[6])
							step_out <= ctrl.cmd[5];
						head_pos <= next_track;
						if (ctrl.cmd[4]) begin   // update flag
							ctrl.track_ld  <= 1'b1;
							ctrl.track_val <= next_track;
						end
					end
					4'h8, 4'h9, 4'ha, 4'hb: begin
						{seek_err, wr_fault, lost_data} <= '0;
						is_write  <= ctrl.cmd[5];
						multi     <= ctrl.cmd[4];
						byte_cnt  <= '0;
						ctrl.busy <= 1'b1;
						if (wp && ctrl.cmd[5]) begin
							wr_fault <= 1'b1;
							state    <= fdc_pkg::end_cmd;
						end else begin
							wait_cnt <= cw'(search_cycles - 1);
							state    <= fdc_pkg::search;
						end
					end
					4'hd: begin              // force interrupt
						type2     <= 1'b0;
						ctrl.busy <= 1'b0;
						ctrl.drq  <= 1'b0;
						state     <= fdc_pkg::abort;
					end
					default: begin           // read address/track, write track
						ctrl.busy <= 1'b1;
						state     <= fdc_pkg::end_cmd;
					end
				endcase
				if (!ctrl.cmd[7]) begin      // all type I commands settle
					head_loaded <= ctrl.cmd[3];
					ctrl.busy   <= 1'b1;
					wait_cnt    <= cw'(settle_cycles - 1);
					state       <= fdc_pkg::settle;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* source/fdc_ctrl_if.sv */
// ====================
// Link between the host register block and the command sequencer.
// The register side hands over commands and strobe events, the
// sequencer returns register loads, read data and status.
// ====================

`timescale 1ns/1ps
`default_nettype none

interface fdc_ctrl_if;

	// from the register block
	logic             cmd_we;
	fdc_pkg::byte_t   cmd;
	logic             data_rd_done;
	logic             data_wr_done;
	fdc_pkg::track_t  track_reg;
	fdc_pkg::sector_t sector_reg;
	fdc_pkg::byte_t   data_reg;

	// from the sequencer
	logic             track_ld;
	fdc_pkg::track_t  track_val;
	logic             sector_ld;
	fdc_pkg::sector_t sector_val;
	fdc_pkg::byte_t   fetched;
	logic             fetched_vld;
	fdc_pkg::byte_t   status;
	logic             busy;
	logic             drq;
	logic             cmd_done;    // one cycle, sets INTRQ

	modport regs (
		output cmd_we, cmd, data_rd_done, data_wr_done, track_reg, sector_reg, data_reg,
		input  track_ld, track_val, sector_ld, sector_val, fetched, fetched_vld,
		input  status, busy, drq, cmd_done
	);

	modport seq (
		input  cmd_we, cmd, data_rd_done, data_wr_done, track_reg, sector_reg, data_reg,
		output track_ld, track_val, sector_ld, sector_val, fetched, fetched_vld,
		output status, busy, drq, cmd_done
	);

endinterface

`default_nettype wire

/* source/fdc_geom_if.sv */
// ====================
// Link between the sequencer and the geometry unit.
// Geometry results are registered, one cycle behind head/sector.
// ====================

`timescale 1ns/1ps
`default_nettype none

interface fdc_geom_if;

	fdc_pkg::track_t    head;
	fdc_pkg::sector_t   sector;

	fdc_pkg::img_addr_t base;        // first byte of the sector in the image
	fdc_pkg::sec_len_t  sec_len;
	fdc_pkg::sector_t   spt;
	logic               in_range;    // 1 <= sector <= spt
	logic [1:0]         size_shift;

	modport seq  (output head, sector, input base, sec_len, spt, in_range, size_shift);
	modport geom (input head, sector, output base, sec_len, spt, in_range, size_shift);

endinterface

`default_nettype wire

/* source/fdc_geometry.sv */
// ====================
// Maps head, side and sector to a byte address in the flat image.
// layout 0 interleaves sides per track, layout 1 puts side 1 in the
// upper half of the image. Outputs are registered.
// ====================

`timescale 1ns/1ps
`default_nettype none

module fdc_geometry (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  fdc_pkg::geom_code_t   size_code,
	input  logic                  layout,
	input  logic                  side,
	input  fdc_pkg::img_addr_t    disk_size,
	fdc_geom_if.geom              geom
);

	fdc_pkg::sector_t   spt_w;
	logic [1:0]         shift_w;
	fdc_pkg::track_t    ts_index;    // track/side index
	fdc_pkg::img_addr_t sec_index;   // sectors from the start of this half
	fdc_pkg::img_addr_t half_base;

	always_comb begin
		spt_w     = fdc_pkg::spt_table[size_code];
		shift_w   = fdc_pkg::size_shift_table[size_code];
		ts_index  = layout ? geom.head : {geom.head[6:0], side};
		sec_index = fdc_pkg::img_addr_t'(ts_index) * fdc_pkg::img_addr_t'(spt_w)
		          + fdc_pkg::img_addr_t'(geom.sector) - fdc_pkg::img_addr_t'(1);
		half_base = (layout && side) ? (disk_size >> 1) : '0;
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			geom.base       <= '0;
			geom.sec_len    <= '0;
			geom.spt        <= '0;
			geom.in_range   <= 1'b0;
			geom.size_shift <= '0;
		end else begin
			geom.base       <= half_base + (sec_index << (7 + shift_w));
			geom.sec_len    <= fdc_pkg::sec_len_t'(11'd128 << shift_w);
			geom.spt        <= spt_w;
			geom.in_range   <= (geom.sector != '0) && (geom.sector <= spt_w);
			geom.size_shift <= shift_w;
		end
	end

endmodule

`default_nettype wire

/* source/fdc_host_regs.sv */
// ====================
// Host side of the controller: strobe edge detect, track/sector/data
// registers, the read mux and the INTRQ flop. Writes act on the rising
// edge of wr, data reads complete on the falling edge of rd.
// ====================

`timescale 1ns/1ps
`default_nettype none

module fdc_host_regs (
	input  logic                clk_sys,
	input  logic                rst_n,
	input  logic                rd,
	input  logic                wr,
	input  fdc_pkg::reg_addr_e  addr,
	input  fdc_pkg::byte_t      din,
	output fdc_pkg::byte_t      dout,
	output logic                intrq,
	fdc_ctrl_if.regs            ctrl
);

	logic               rd_q;
	logic               wr_q;
	fdc_pkg::reg_addr_e cur_addr;   // address of the access in progress

	wire rd_fall = rd_q & ~rd;
	wire wr_rise = wr & ~wr_q;
	wire wr_fall = wr_q & ~wr;
	wire strobe_rise = (rd & ~rd_q) | wr_rise;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			rd_q              <= 1'b0;
			wr_q              <= 1'b0;
			cur_addr          <= fdc_pkg::cmd_status;
			ctrl.cmd_we       <= 1'b0;
			ctrl.data_rd_done <= 1'b0;
			ctrl.data_wr_done <= 1'b0;
			ctrl.track_reg    <= '0;
			ctrl.sector_reg   <= '0;
			ctrl.data_reg     <= '0;
			intrq             <= 1'b0;
		end else begin
			rd_q <= rd;
			wr_q <= wr;
			if (strobe_rise)
				cur_addr <= addr;

			ctrl.cmd_we       <= wr_rise && (addr == fdc_pkg::cmd_status);
			ctrl.data_rd_done <= rd_fall && (cur_addr == fdc_pkg::data);
			ctrl.data_wr_done <= wr_fall && (cur_addr == fdc_pkg::data);

			// sequencer loads win over host writes
			if (ctrl.track_ld)
				ctrl.track_reg <= ctrl.track_val;
			else if (wr_rise && addr == fdc_pkg::track && !ctrl.busy)
				ctrl.track_reg <= din;

			if (ctrl.sector_ld)
				ctrl.sector_reg <= ctrl.sector_val;
			else if (wr_rise && addr == fdc_pkg::sector && !ctrl.busy)
				ctrl.sector_reg <= din;

			if (wr_rise && addr == fdc_pkg::data)
				ctrl.data_reg <= din;

			// status read or new command acknowledges the interrupt
			if (ctrl.cmd_done)
				intrq <= 1'b1;
			else if ((rd_fall && cur_addr == fdc_pkg::cmd_status) ||
			         (wr_rise && addr == fdc_pkg::cmd_status))
				intrq <= 1'b0;
		end
	end

	// command byte latch
	always_ff @(posedge clk_sys) begin
		if (wr_rise && addr == fdc_pkg::cmd_status)
			ctrl.cmd <= din;
	end

	always_comb begin
		case (addr)
			fdc_pkg::cmd_status: dout = ctrl.status;
			fdc_pkg::track:      dout = ctrl.track_reg;
			fdc_pkg::sector:     dout = ctrl.sector_reg;
			default:             dout = ctrl.fetched_vld ? ctrl.fetched : ctrl.data_reg;
		endcase
	end

endmodule

`default_nettype wire

/* source/fdc_pkg.sv */
// ====================
// Shared types and geometry tables for the WD1793-style floppy controller.
// Every design file refers to these through fdc_pkg:: scoped names.
// ====================

`default_nettype none

package fdc_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [7:0]  track_t;
	typedef logic [7:0]  sector_t;
	typedef logic [20:0] img_addr_t;   // 2 MB image max
	typedef logic [10:0] sec_len_t;    // up to 1024 bytes per sector
	typedef logic [2:0]  geom_code_t;

	// host register map
	typedef enum logic [1:0] {
		cmd_status = 2'd0,
		track      = 2'd1,
		sector     = 2'd2,
		data       = 2'd3
	} reg_addr_e;

	typedef enum logic [3:0] {
		idle,
		settle,       // type I busy time
		search,       // type II start delay and range check
		fetch,
		fetch_wait,
		drq_delay,
		drq_wait,
		store,        // write-back slot, reads just pass through
		abort,
		end_cmd
	} seq_state_e;

	// ==================
	// fixed track layouts
	// ==================
	// 0: 26x128  1: 16x256  2: 9x512  3: 5x1024  4: 10x512
	// codes 5..7 fall back to layout 0
	localparam sector_t spt_table [8] = '{
		8'd26, 8'd16, 8'd9, 8'd5, 8'd10, 8'd26, 8'd26, 8'd26
	};

	// sector length is 128 << shift
	localparam logic [1:0] size_shift_table [8] = '{
		2'd0, 2'd1, 2'd2, 2'd3, 2'd2, 2'd0, 2'd0, 2'd0
	};

endpackage

`default_nettype wire

/* source/fdc_top.sv */
// ====================
// Top level of the floppy controller. Host bus, drive inputs and the
// image memory port are plain ports, timing parameters pass down
// to the sequencer.
// ====================

`timescale 1ns/1ps
`default_nettype none

module fdc_top #(
	parameter int settle_cycles = 64,
	parameter int search_cycles = 32,
	parameter int drq_delay     = 16,
	parameter int lost_timeout  = 4096
) (
	input  logic                clk_sys,
	input  logic                rst_n,
	// host bus
	input  logic                rd,
	input  logic                wr,
	input  fdc_pkg::reg_addr_e  addr,
	input  fdc_pkg::byte_t      din,
	output fdc_pkg::byte_t      dout,
	output logic                drq,
	output logic                intrq,
	output logic                busy,
	// drive
	input  logic                wp,
	input  logic                ready,
	input  logic                side,
	input  logic                layout,      // 0 track-side-sector, 1 side-track-sector
	input  fdc_pkg::geom_code_t size_code,
	input  fdc_pkg::img_addr_t  disk_size,
	// image memory
	output fdc_pkg::img_addr_t  img_addr,
	output logic                img_rd,
	output logic                img_wr,
	output fdc_pkg::byte_t      img_wdata,
	input  fdc_pkg::byte_t      img_rdata
);

	fdc_ctrl_if ctrl ();
	fdc_geom_if geom ();

	assign drq  = ctrl.drq;
	assign busy = ctrl.busy;

	fdc_host_regs u_regs (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.rd      (rd),
		.wr      (wr),
		.addr    (addr),
		.din     (din),
		.dout    (dout),
		.intrq   (intrq),
		.ctrl    (ctrl.regs)
	);

	fdc_cmd_seq #(
		.settle_cycles (settle_cycles),
		.search_cycles (search_cycles),
		.drq_delay     (drq_delay),
		.lost_timeout  (lost_timeout)
	) u_seq (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.wp        (wp),
		.ready     (ready),
		.img_addr  (img_addr),
		.img_rd    (img_rd),
		.img_wr    (img_wr),
		.img_wdata (img_wdata),
		.img_rdata (img_rdata),
		.ctrl      (ctrl.seq),
		.geom      (geom.seq)
	);

	fdc_geometry u_geom (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.size_code (size_code),
		.layout    (layout),
		.side      (side),
		.disk_size (disk_size),
		.geom      (geom.geom)
	);

endmodule

`default_nettype wire

/* src.f */
source/fdc_pkg.sv
source/fdc_ctrl_if.sv
source/fdc_geom_if.sv
source/fdc_host_regs.sv
source/fdc_geometry.sv
source/fdc_cmd_seq.sv
source/fdc_top.sv
sim/fdc_asserts.sv
sim/fdc_tb.sv
